// ==== rtl/cpu_alu.sv ====
`timescale 1ns/10ps

module cpu_alu (
    input  cpu_pkg::alu_op_t op,
    input  logic [7:0]       a,
    input  logic [7:0]       x,
    input  logic [7:0]       operand,
    input  logic             carry_in,
    output logic [7:0]       result,
    output logic             n_out,
    output logic             z_out,
    output logic             c_out,
    output logic             v_out
);

    logic [8:0] sum;

    // binary add only, no decimal mode
    assign sum = {1'b0, a} + {1'b0, operand} + {8'd0, carry_in};

    always_comb begin
        result = operand;
        c_out = carry_in;
        v_out = 1'b0;
        case (op)
            cpu_pkg::ALU_PASS_OPERAND: result = operand;
            cpu_pkg::ALU_PASS_A:       result = a;
            cpu_pkg::ALU_PASS_X:       result = x;
            cpu_pkg::ALU_INC:          result = operand + 8'd1;
            cpu_pkg::ALU_DEC:          result = operand - 8'd1;
            cpu_pkg::ALU_ADC: begin
                result = sum[7:0];
                c_out = sum[8];
                // same input signs, result sign flipped
                v_out = (a[7] == operand[7]) && (sum[7] != a[7]);
            end
            cpu_pkg::ALU_SEC: begin
                result = a;
                c_out = 1'b1;
            end
            cpu_pkg::ALU_CLC: begin
                result = a;
                c_out = 1'b0;
            end
            default: result = operand;
        endcase
    end

    assign n_out = result[7];
    assign z_out = (result == 8'h00);

endmodule

// ==== rtl/cpu_core.sv ====
`timescale 1ns/10ps

module cpu_core #(
    parameter logic [15:0] RESET_PC = 16'h0200
) (
    input  logic        clock,
    input  logic        reset_n,
    input  logic        start,
    mem_bus_if.core     bus,
    output logic        halted,
    output logic        retire,
    output logic [15:0] retire_pc,
    output logic [7:0]  retire_a,
    output logic [7:0]  retire_x,
    output logic [7:0]  retire_y,
    output logic [7:0]  retire_status,
    output logic [7:0]  retire_sp
);

    cpu_pkg::processor_state_t state;
    cpu_pkg::ctrl_word_t       ctrl;

    logic [15:0] pc;
    logic [15:0] instr_pc;
    logic [15:0] operand;
    logic [7:0]  opcode;
    logic [7:0]  decode_in;
    logic [7:0]  a;
    logic [7:0]  x;
    logic [7:0]  y;
    logic [7:0]  sp;
    logic        n_flag;
    logic        v_flag;
    logic        d_flag;
    logic        i_flag;
    logic        z_flag;
    logic        c_flag;

    logic [7:0]  alu_operand;
    logic [7:0]  alu_result;
    logic        alu_n;
    logic        alu_z;
    logic        alu_c;
    logic        alu_v;

    logic        commit;
    logic        branch_taken;
    logic        mem_op;
    logic [7:0]  next_a;
    logic [7:0]  next_x;
    logic [7:0]  next_y;
    logic        next_n;
    logic        next_v;
    logic        next_z;
    logic        next_c;

    // opcode arrives on r_data during decode, then comes from the register
    assign decode_in = (state == cpu_pkg::STATE_DECODE) ? bus.r_data : opcode;

    cpu_decoder decoder0 (
        .opcode(decode_in),
        .ctrl  (ctrl)
    );

    always_comb begin
        if (state == cpu_pkg::STATE_MEM_ACCESS) begin
            alu_operand = bus.r_data;
        end else if (ctrl.alu_op == cpu_pkg::ALU_INC || ctrl.alu_op == cpu_pkg::ALU_DEC) begin
            alu_operand = (ctrl.dest == cpu_pkg::DEST_X) ? x : y;
        end else begin
            alu_operand = operand[7:0];
        end
    end

    cpu_alu alu0 (
        .op      (ctrl.alu_op),
        .a       (a),
        .x       (x),
        .operand (alu_operand),
        .carry_in(c_flag),
        .result  (alu_result),
        .n_out   (alu_n),
        .z_out   (alu_z),
        .c_out   (alu_c),
        .v_out   (alu_v)
    );

    assign mem_op = ctrl.reads_mem || ctrl.writes_mem;
    assign commit = bus.clock_en &&
                    ((state == cpu_pkg::STATE_EXECUTE && !mem_op) ||
                     state == cpu_pkg::STATE_MEM_ACCESS);
    assign branch_taken = ctrl.is_branch && (z_flag == ctrl.branch_on_zero);

    // architectural state as it will be after this instruction
    assign next_a = (ctrl.dest == cpu_pkg::DEST_A) ? alu_result : a;
    assign next_x = (ctrl.dest == cpu_pkg::DEST_X) ? alu_result : x;
    assign next_y = (ctrl.dest == cpu_pkg::DEST_Y) ? alu_result : y;
    assign next_n = ctrl.updates_nz ? alu_n : n_flag;
    assign next_z = ctrl.updates_nz ? alu_z : z_flag;
    assign next_c = ctrl.updates_cv ? alu_c : c_flag;
    assign next_v = (ctrl.updates_cv && ctrl.alu_op == cpu_pkg::ALU_ADC) ? alu_v : v_flag;

    always_comb begin
        bus.addr = pc;
        bus.r_en = 1'b0;
        bus.w_en = 1'b0;
        bus.w_data = a;
        case (state)
            cpu_pkg::STATE_FETCH:      bus.r_en = 1'b1;
            cpu_pkg::STATE_DECODE:     bus.r_en = bus.clock_en && (ctrl.operand_bytes != 2'd0);
            cpu_pkg::STATE_OPERAND_LO: bus.r_en = bus.clock_en && (ctrl.operand_bytes == 2'd2);
            cpu_pkg::STATE_EXECUTE: begin
                bus.addr = operand;
                bus.r_en = ctrl.reads_mem;
            end
            cpu_pkg::STATE_MEM_ACCESS: begin
                bus.addr = operand;
                bus.w_en = ctrl.writes_mem;
            end
            default: bus.r_en = 1'b0;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= cpu_pkg::STATE_HALT;
            pc <= RESET_PC;
            instr_pc <= '0;
            opcode <= cpu_pkg::OP_BRK;
            operand <= '0;
            a <= '0;
            x <= '0;
            y <= '0;
            sp <= cpu_pkg::SP_RESET;
            {n_flag, v_flag} <= cpu_pkg::STATUS_RESET[7:6];
            {d_flag, i_flag, z_flag, c_flag} <= cpu_pkg::STATUS_RESET[3:0];
        end else if (state == cpu_pkg::STATE_HALT) begin
            if (start) begin
                pc <= RESET_PC;
                state <= cpu_pkg::STATE_FETCH;
            end
        end else if (bus.clock_en) begin
            case (state)
                cpu_pkg::STATE_FETCH: begin
                    instr_pc <= pc;
                    pc <= pc + 16'd1;
                    state <= cpu_pkg::STATE_DECODE;
                end
                cpu_pkg::STATE_DECODE: begin
                    opcode <= bus.r_data;
                    if (ctrl.operand_bytes != 2'd0) begin
                        pc <= pc + 16'd1;
                        state <= cpu_pkg::STATE_OPERAND_LO;
                    end else begin
                        state <= cpu_pkg::STATE_EXECUTE;
                    end
                end
                cpu_pkg::STATE_OPERAND_LO: begin
                    operand <= {8'h00, bus.r_data};
                    if (ctrl.operand_bytes == 2'd2) begin
                        pc <= pc + 16'd1;
                        state <= cpu_pkg::STATE_OPERAND_HI;
                    end else begin
                        state <= cpu_pkg::STATE_EXECUTE;
                    end
                end
                cpu_pkg::STATE_OPERAND_HI: begin
                    operand[15:8] <= bus.r_data;
                    state <= cpu_pkg::STATE_EXECUTE;
                end
                cpu_pkg::STATE_EXECUTE: begin
                    if (mem_op) begin
                        state <= cpu_pkg::STATE_MEM_ACCESS;
                    end else if (ctrl.halts) begin
                        state <= cpu_pkg::STATE_HALT;
                    end else begin
                        state <= cpu_pkg::STATE_FETCH;
                    end
                    // pc already points past the operand
                    if (ctrl.is_jump) begin
                        pc <= operand;
                    end else if (branch_taken) begin
                        pc <= pc + {{8{operand[7]}}, operand[7:0]};
                    end
                end
                cpu_pkg::STATE_MEM_ACCESS: state <= cpu_pkg::STATE_FETCH;
                default: state <= cpu_pkg::STATE_HALT;
            endcase
            if (commit) begin
                a <= next_a;
                x <= next_x;
                y <= next_y;
                n_flag <= next_n;
                v_flag <= next_v;
                z_flag <= next_z;
                c_flag <= next_c;
            end
        end
    end

    assign halted = (state == cpu_pkg::STATE_HALT);
    assign retire = commit;
    assign retire_pc = instr_pc;
    assign retire_a = next_a;
    assign retire_x = next_x;
    assign retire_y = next_y;
    assign retire_status = {next_n, next_v, 1'b1, 1'b0, d_flag, i_flag, next_z, next_c};
    assign retire_sp = sp;

    a_no_read_write: assert property (
        @(posedge clock) disable iff (!reset_n) !(bus.r_en && bus.w_en)
    ) else $error("core: read and write strobes together");

    a_no_retire_halted: assert property (
        @(posedge clock) disable iff (!reset_n) (state == cpu_pkg::STATE_HALT) |-> !retire
    ) else $error("core: retire while halted");

endmodule

// ==== rtl/cpu_decoder.sv ====
`timescale 1ns/10ps

module cpu_decoder (
    input  logic [7:0]          opcode,
    output cpu_pkg::ctrl_word_t ctrl
);

    always_comb begin
        ctrl = '0;
        case (opcode)
            cpu_pkg::OP_LDA_IMM, cpu_pkg::OP_LDX_IMM, cpu_pkg::OP_LDY_IMM: begin
                ctrl.operand_bytes = 2'd1;
                ctrl.alu_op = cpu_pkg::ALU_PASS_OPERAND;
                ctrl.updates_nz = 1'b1;
                if (opcode == cpu_pkg::OP_LDA_IMM) begin
                    ctrl.dest = cpu_pkg::DEST_A;
                end else if (opcode == cpu_pkg::OP_LDX_IMM) begin
                    ctrl.dest = cpu_pkg::DEST_X;
                end else begin
                    ctrl.dest = cpu_pkg::DEST_Y;
                end
            end
            cpu_pkg::OP_LDA_ABS: begin
                ctrl.operand_bytes = 2'd2;
                ctrl.alu_op = cpu_pkg::ALU_PASS_OPERAND;
                ctrl.dest = cpu_pkg::DEST_A;
                ctrl.reads_mem = 1'b1;
                ctrl.updates_nz = 1'b1;
            end
            cpu_pkg::OP_STA_ABS: begin
                ctrl.operand_bytes = 2'd2;
                ctrl.alu_op = cpu_pkg::ALU_PASS_A;
                ctrl.writes_mem = 1'b1;
            end
            cpu_pkg::OP_TAX, cpu_pkg::OP_TAY: begin
                ctrl.alu_op = cpu_pkg::ALU_PASS_A;
                ctrl.updates_nz = 1'b1;
                ctrl.dest = (opcode == cpu_pkg::OP_TAX) ? cpu_pkg::DEST_X : cpu_pkg::DEST_Y;
            end
            cpu_pkg::OP_INX, cpu_pkg::OP_DEX: begin
                ctrl.alu_op = (opcode == cpu_pkg::OP_INX) ? cpu_pkg::ALU_INC : cpu_pkg::ALU_DEC;
                ctrl.dest = cpu_pkg::DEST_X;
                ctrl.updates_nz = 1'b1;
            end
            cpu_pkg::OP_INY, cpu_pkg::OP_DEY: begin
                ctrl.alu_op = (opcode == cpu_pkg::OP_INY) ? cpu_pkg::ALU_INC : cpu_pkg::ALU_DEC;
                ctrl.dest = cpu_pkg::DEST_Y;
                ctrl.updates_nz = 1'b1;
            end
            cpu_pkg::OP_ADC_IMM: begin
                ctrl.operand_bytes = 2'd1;
                ctrl.alu_op = cpu_pkg::ALU_ADC;
                ctrl.dest = cpu_pkg::DEST_A;
                ctrl.updates_nz = 1'b1;
                ctrl.updates_cv = 1'b1;
            end
            cpu_pkg::OP_CLC, cpu_pkg::OP_SEC: begin
                ctrl.alu_op = (opcode == cpu_pkg::OP_SEC) ? cpu_pkg::ALU_SEC : cpu_pkg::ALU_CLC;
                ctrl.updates_cv = 1'b1;
            end
            cpu_pkg::OP_NOP: begin
                ctrl.alu_op = cpu_pkg::ALU_PASS_OPERAND;
            end
            cpu_pkg::OP_JMP_ABS: begin
                ctrl.operand_bytes = 2'd2;
                ctrl.is_jump = 1'b1;
            end
            cpu_pkg::OP_BNE, cpu_pkg::OP_BEQ: begin
                ctrl.operand_bytes = 2'd1;
                ctrl.is_branch = 1'b1;
                ctrl.branch_on_zero = (opcode == cpu_pkg::OP_BEQ);
            end
            // BRK and anything undefined stop the core
            default: begin
                ctrl.halts = 1'b1;
            end
        endcase

        assert final (!(ctrl.reads_mem && ctrl.writes_mem))
            else $error("decoder: opcode %h both reads and writes memory", opcode);
    end

endmodule

// ==== rtl/cpu_memory.sv ====
`timescale 1ns/10ps

module cpu_memory #(
    parameter int MEM_ADDR_BITS = 12,
    parameter int READ_WAIT     = 1
) (
    input  logic        clock,
    input  logic        reset_n,
    mem_bus_if.memory   bus,
    input  logic        load_en,
    input  logic [15:0] load_addr,
    input  logic [7:0]  load_data
);

    localparam int DEPTH     = 1 << MEM_ADDR_BITS;
    localparam int WAIT_BITS = (READ_WAIT > 0) ? $clog2(READ_WAIT + 1) : 1;

    logic [7:0]           mem [DEPTH];
    logic [WAIT_BITS-1:0] wait_cnt;
    logic                 read_start;

    // a new read is only taken when nothing is pending
    assign read_start = bus.r_en && bus.clock_en;
    assign bus.clock_en = (wait_cnt == '0);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wait_cnt <= '0;
        end else if (read_start) begin
            wait_cnt <= WAIT_BITS'(READ_WAIT);
        end else if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

    // addresses wrap at the memory depth
    always_ff @(posedge clock) begin
        if (read_start) begin
            bus.r_data <= mem[bus.addr[MEM_ADDR_BITS-1:0]];
        end
        if (bus.w_en) begin
            mem[bus.addr[MEM_ADDR_BITS-1:0]] <= bus.w_data;
        end
        if (load_en) begin
            mem[load_addr[MEM_ADDR_BITS-1:0]] <= load_data;
        end
    end

    a_load_idle: assert property (
        @(posedge clock) disable iff (!reset_n) load_en |-> bus.clock_en
    ) else $error("memory: load during a pending read");

endmodule

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

    typedef enum logic [2:0] {
        STATE_HALT,
        STATE_FETCH,
        STATE_DECODE,
        STATE_OPERAND_LO,
        STATE_OPERAND_HI,
        STATE_EXECUTE,
        STATE_MEM_ACCESS
    } processor_state_t;

    typedef enum logic [2:0] {
        ALU_PASS_OPERAND,
        ALU_PASS_A,
        ALU_PASS_X,
        ALU_INC,
        ALU_DEC,
        ALU_ADC,
        ALU_SEC,
        ALU_CLC
    } alu_op_t;

    typedef enum logic [1:0] {
        DEST_NONE,
        DEST_A,
        DEST_X,
        DEST_Y
    } dest_t;

    // one decoded instruction in 15 bits
    typedef struct packed {
        logic [1:0] operand_bytes;
        alu_op_t    alu_op;
        dest_t      dest;
        logic       reads_mem;
        logic       writes_mem;
        logic       is_jump;
        logic       is_branch;
        logic       branch_on_zero;
        logic       updates_nz;
        logic       updates_cv;
        logic       halts;
    } ctrl_word_t;

    localparam logic [7:0] OP_LDA_IMM = 8'hA9;
    localparam logic [7:0] OP_LDX_IMM = 8'hA2;
    localparam logic [7:0] OP_LDY_IMM = 8'hA0;
    localparam logic [7:0] OP_LDA_ABS = 8'hAD;
    localparam logic [7:0] OP_STA_ABS = 8'h8D;
    localparam logic [7:0] OP_TAX     = 8'hAA;
    localparam logic [7:0] OP_TAY     = 8'hA8;
    localparam logic [7:0] OP_INX     = 8'hE8;
    localparam logic [7:0] OP_INY     = 8'hC8;
    localparam logic [7:0] OP_DEX     = 8'hCA;
    localparam logic [7:0] OP_DEY     = 8'h88;
    localparam logic [7:0] OP_ADC_IMM = 8'h69;
    localparam logic [7:0] OP_CLC     = 8'h18;
    localparam logic [7:0] OP_SEC     = 8'h38;
    localparam logic [7:0] OP_NOP     = 8'hEA;
    localparam logic [7:0] OP_JMP_ABS = 8'h4C;
    localparam logic [7:0] OP_BNE     = 8'hD0;
    localparam logic [7:0] OP_BEQ     = 8'hF0;
    localparam logic [7:0] OP_BRK     = 8'h00;

    localparam logic [7:0] SP_RESET     = 8'hFD;
    // bit 5 and I set
    localparam logic [7:0] STATUS_RESET = 8'h24;

endpackage

// ==== rtl/cpu_system.sv ====
`timescale 1ns/10ps

module cpu_system #(
    parameter logic [15:0] RESET_PC      = 16'h0200,
    parameter int          MEM_ADDR_BITS = 12,
    parameter int          READ_WAIT     = 1
) (
    input  logic        clock,
    input  logic        reset_n,
    input  logic        load_en,
    input  logic [15:0] load_addr,
    input  logic [7:0]  load_data,
    input  logic        start,
    output logic        halted,
    output logic        retire,
    output logic [15:0] retire_pc,
    output logic [7:0]  retire_a,
    output logic [7:0]  retire_x,
    output logic [7:0]  retire_y,
    output logic [7:0]  retire_status,
    output logic [7:0]  retire_sp
);

    mem_bus_if bus ();

    cpu_core #(
        .RESET_PC(RESET_PC)
    ) core0 (
        .clock,
        .reset_n,
        .start,
        .bus          (bus.core),
        .halted,
        .retire,
        .retire_pc,
        .retire_a,
        .retire_x,
        .retire_y,
        .retire_status,
        .retire_sp
    );

    // load port bypasses the core
    cpu_memory #(
        .MEM_ADDR_BITS(MEM_ADDR_BITS),
        .READ_WAIT    (READ_WAIT)
    ) mem0 (
        .clock,
        .reset_n,
        .bus      (bus.memory),
        .load_en,
        .load_addr,
        .load_data
    );

endmodule

// ==== rtl/mem_bus_if.sv ====
`timescale 1ns/10ps

interface mem_bus_if;
    logic [15:0] addr;
    logic        r_en;
    logic        w_en;
    logic [7:0]  w_data;
    logic [7:0]  r_data;
    // low while a read is still pending
    logic        clock_en;

    modport core (
        output addr,
        output r_en,
        output w_en,
        output w_data,
        input  r_data,
        input  clock_en
    );

    modport memory (
        input  addr,
        input  r_en,
        input  w_en,
        input  w_data,
        output r_data,
        output clock_en
    );
endinterface

// ==== src.f ====
rtl/cpu_pkg.sv
rtl/mem_bus_if.sv
rtl/cpu_decoder.sv
rtl/cpu_alu.sv
rtl/cpu_core.sv
rtl/cpu_memory.sv
rtl/cpu_system.sv
verification/trace_checker.sv
verification/tb_top.sv

// ==== verification/cpu_tests.txt ====
# P addr count bytes | E pc a x y status sp | G cycle limit
# R base count: NOPs at shuffled addresses, count a power of two
# immediate loads and transfers
P 0200 8 A9 00 A2 80 A0 7F A9 FF
P 0208 5 AA A8 E8 88 00
E 0200 00 00 00 26 FD
E 0202 00 80 00 A4 FD
E 0204 00 80 7F 24 FD
E 0206 FF 80 7F A4 FD
E 0208 FF FF 7F A4 FD
E 0209 FF FF FF A4 FD
E 020A FF 00 FF 26 FD
E 020B FF 00 FE A4 FD
E 020C FF 00 FE A4 FD
G 500
# adc with carry, overflow and zero results
P 0200 8 18 A9 50 69 50 38 69 5F
P 0208 8 18 A9 FF 69 01 38 69 7F
P 0210 1 00
E 0200 00 00 00 24 FD
E 0201 50 00 00 24 FD
E 0203 A0 00 00 E4 FD
E 0205 A0 00 00 E5 FD
E 0206 00 00 00 27 FD
E 0208 00 00 00 26 FD
E 0209 FF 00 00 A4 FD
E 020B 00 00 00 27 FD
E 020D 00 00 00 27 FD
E 020E 80 00 00 E4 FD
E 0210 80 00 00 E4 FD
G 500
# store and load back through the read wait
P 0200 8 A9 5A 8D 00 03 A9 00 AD
P 0208 8 00 03 A9 C3 8D 01 03 AD
P 0210 6 00 03 AD 01 03 00
E 0200 5A 00 00 24 FD
E 0202 5A 00 00 24 FD
E 0205 00 00 00 26 FD
E 0207 5A 00 00 24 FD
E 020A C3 00 00 A4 FD
E 020C C3 00 00 A4 FD
E 020F 5A 00 00 24 FD
E 0212 C3 00 00 A4 FD
E 0215 C3 00 00 A4 FD
G 500
# counted loop, taken beq, jmp over inx traps
P 0200 8 A2 03 CA D0 FD F0 02 E8
P 0208 8 E8 4C 10 02 E8 E8 E8 E8
P 0210 3 A0 44 00
E 0200 00 03 00 24 FD
E 0202 00 02 00 24 FD
E 0203 00 02 00 24 FD
E 0202 00 01 00 24 FD
E 0203 00 01 00 24 FD
E 0202 00 00 00 26 FD
E 0203 00 00 00 26 FD
E 0205 00 00 00 26 FD
E 0209 00 00 00 26 FD
E 0210 00 00 44 24 FD
E 0212 00 00 44 24 FD
G 500
# undefined opcode halts
P 0200 4 E8 02 E8 E8
E 0200 00 01 00 24 FD
E 0201 00 01 00 24 FD
G 500
# nop area written in random order
R 0200 4
P 0204 1 00
E 0200 00 00 00 24 FD
E 0201 00 00 00 24 FD
E 0202 00 00 00 24 FD
E 0203 00 00 00 24 FD
E 0204 00 00 00 24 FD
G 500

// ==== verification/tb_top.sv ====
`timescale 1ns/10ps

module tb_top;

    localparam logic [15:0] RESET_PC  = 16'h0200;
    localparam int          READ_WAIT = 2;
    localparam logic [7:0]  NOP_BYTE  = 8'hEA;

    logic        clock;
    logic        reset_n;
    logic        load_en;
    logic [15:0] load_addr;
    logic [7:0]  load_data;
    logic        start;
    logic        halted;
    logic        retire;
    logic [15:0] retire_pc;
    logic [7:0]  retire_a;
    logic [7:0]  retire_x;
    logic [7:0]  retire_y;
    logic [7:0]  retire_status;
    logic [7:0]  retire_sp;

    integer      seed;
    integer      hang_count;
    integer      record_errors;

    cpu_system #(
        .RESET_PC     (RESET_PC),
        .MEM_ADDR_BITS(12),
        .READ_WAIT    (READ_WAIT)
    ) dut0 (
        .clock,
        .reset_n,
        .load_en,
        .load_addr,
        .load_data,
        .start,
        .halted,
        .retire,
        .retire_pc,
        .retire_a,
        .retire_x,
        .retire_y,
        .retire_status,
        .retire_sp
    );

    trace_checker checker0 (
        .clock,
        .reset_n,
        .halted,
        .retire,
        .retire_pc,
        .retire_a,
        .retire_x,
        .retire_y,
        .retire_status,
        .retire_sp
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    task automatic apply_reset();
        @(posedge clock);
        reset_n <= 1'b0;
        repeat (3) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        checker0.check_halted();
    endtask

    task automatic load_byte(input logic [15:0] addr, input logic [7:0] data);
        @(posedge clock);
        load_en <= 1'b1;
        load_addr <= addr;
        load_data <= data;
    endtask

    // odd stride over a power-of-two area visits every byte once
    task automatic fill_nop_area(input logic [15:0] base, input integer count);
        integer offset;
        integer stride;
        integer i;
        offset = $unsigned($random(seed)) % count;
        stride = ($unsigned($random(seed)) % count) | 1;
        for (i = 0; i < count; i = i + 1) begin
            load_byte(base + 16'((offset + i * stride) % count), NOP_BYTE);
        end
    endtask

    task automatic run_program(input integer limit);
        integer cycles;
        @(posedge clock);
        load_en <= 1'b0;
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
        cycles = 0;
        @(negedge clock);
        while (halted !== 1'b1 && cycles < limit) begin
            @(negedge clock);
            cycles = cycles + 1;
        end
        if (halted !== 1'b1) begin
            $display("program did not halt within %0d cycles (time %0t)", limit, $time);
            hang_count = hang_count + 1;
        end
        checker0.end_test();
        apply_reset();
    endtask

    initial begin : main_flow
        integer            fd;
        integer            code;
        integer            count;
        integer            limit;
        integer            i;
        integer            total;
        logic [7:0]        kind;
        logic [15:0]       addr;
        logic [7:0]        data_byte;
        logic [15:0]       pc;
        logic [7:0]        a;
        logic [7:0]        x;
        logic [7:0]        y;
        logic [7:0]        st;
        logic [7:0]        sp;
        logic [8*256-1:0]  comment_text;

        seed = 94967;
        hang_count = 0;
        record_errors = 0;
        reset_n = 1'b0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        start = 1'b0;
        apply_reset();

        fd = $fopen("verification/cpu_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open verification/cpu_tests.txt");
            $display("Some tests failed");
            $finish;
        end else begin
            while ($fscanf(fd, " %c", kind) == 1) begin
                case (kind)
                    "#": code = $fgets(comment_text, fd);
                    "P": begin
                        code = $fscanf(fd, "%h %d", addr, count);
                        for (i = 0; i < count; i = i + 1) begin
                            code = $fscanf(fd, "%h", data_byte);
                            load_byte(addr + 16'(i), data_byte);
                        end
                    end
                    "E": begin
                        code = $fscanf(fd, "%h %h %h %h %h %h", pc, a, x, y, st, sp);
                        if (code != 6) begin
                            $display("malformed expected record after pc %h", pc);
                            record_errors = record_errors + 1;
                        end
                        checker0.add_expected({pc, a, x, y, st, sp});
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %d", addr, count);
                        fill_nop_area(addr, count);
                    end
                    "G": begin
                        code = $fscanf(fd, "%d", limit);
                        run_program(limit);
                    end
                    default: begin
                        $display("unknown record type '%c' in the tests file", kind);
                        record_errors = record_errors + 1;
                    end
                endcase
            end
            $fclose(fd);

            if (checker0.checked_count == 0) begin
                $display("no retire was ever compared");
                record_errors = record_errors + 1;
            end
            total = checker0.mismatch_count + checker0.extra_count + checker0.missing_count +
                    checker0.state_count + hang_count + record_errors;
            $display("errors: %0d mismatch, %0d extra, %0d missing, %0d halt, %0d hang, %0d file",
                     checker0.mismatch_count, checker0.extra_count, checker0.missing_count,
                     checker0.state_count, hang_count, record_errors);
            if (total == 0) begin
                $display("All tests passed");
            end else begin
                $display("Some tests failed");
            end
            $finish;
        end
    end

endmodule

// ==== verification/trace_checker.sv ====
`timescale 1ns/10ps

module trace_checker (
    input logic        clock,
    input logic        reset_n,
    input logic        halted,
    input logic        retire,
    input logic [15:0] retire_pc,
    input logic [7:0]  retire_a,
    input logic [7:0]  retire_x,
    input logic [7:0]  retire_y,
    input logic [7:0]  retire_status,
    input logic [7:0]  retire_sp
);

    // pc, a, x, y, status, sp from high to low
    logic [55:0] expected_q [$];

    integer mismatch_count;
    integer extra_count;
    integer missing_count;
    integer state_count;
    integer checked_count;

    initial begin
        mismatch_count = 0;
        extra_count = 0;
        missing_count = 0;
        state_count = 0;
        checked_count = 0;
    end

    task automatic add_expected(input logic [55:0] rec);
        expected_q.push_back(rec);
    endtask

    task automatic check_halted();
        if (halted !== 1'b1) begin
            $display("core is not halted after reset (time %0t)", $time);
            state_count = state_count + 1;
        end
    endtask

    // whatever is left over never retired
    task automatic end_test();
        if (expected_q.size() != 0) begin
            $display("%0d expected retires did not happen, first missing pc %h",
                     expected_q.size(), expected_q[0][55:40]);
            missing_count = missing_count + expected_q.size();
            expected_q.delete();
        end
    endtask

    task automatic compare_field(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0t: retire %s expected %0h got %0h",
                     $time, name, expected, actual);
            mismatch_count = mismatch_count + 1;
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clock) begin : watch_retire
        logic [55:0] rec;
        if (reset_n === 1'b1 && retire === 1'b1) begin
            if (expected_q.size() == 0) begin
                $display("unexpected retire at pc %h (time %0t)", retire_pc, $time);
                extra_count = extra_count + 1;
            end else begin
                rec = expected_q.pop_front();
                checked_count = checked_count + 1;
                compare_field("pc", rec[55:40], retire_pc);
                compare_field("a", {8'h00, rec[39:32]}, {8'h00, retire_a});
                compare_field("x", {8'h00, rec[31:24]}, {8'h00, retire_x});
                compare_field("y", {8'h00, rec[23:16]}, {8'h00, retire_y});
                compare_field("status", {8'h00, rec[15:8]}, {8'h00, retire_status});
                compare_field("sp", {8'h00, rec[7:0]}, {8'h00, retire_sp});
            end
        end
    end

endmodule
